// ==== compile.f ====
common/memPkg.sv
hw/reqQueue.sv
hw/memCtrl/byteRam.sv
hw/memCtrl/memCtrl.sv
hw/memSubsys.sv
sim/memSubsys_properties.sv
sim/memSubsys_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

verilator --binary --assert -Wno-fatal --top-module memSubsys_tb -f compile.f -o simv

out=$(./obj_dir/simv 2>&1) || true
echo "$out"
echo "$out" | grep -qx "Simulation finished: PASS"

// ==== sim/memSubsys_tb.sv ====
module memSubsys_tb
    import memPkg::*;
();
    localparam int QueueDepth = 4;
    localparam int RamAddrW = 10;
    localparam int TimeoutCycles = 5000;
    localparam int Seed = 23;
    // every test address stays inside the filled window
    localparam int WindowBytes = 96;

    logic clk;
    logic rst;
    logic ioFull;
    logic instValid;
    logic [memAddrW-1:0] instAddr;
    logic dataValid;
    memOpT dataOp;
    accessLenT dataLen;
    logic [memAddrW-1:0] dataAddr;
    logic [31:0] dataWdata;
    logic instCredit;
    logic dataCredit;
    logic instDone;
    logic [31:0] instWord;
    logic dataDone;
    logic [31:0] dataRdata;

    logic [7:0] refMem [2 ** RamAddrW];
    logic [31:0] instExp [$];
    logic [31:0] dataExp [$];
    int fetchMark [$];
    int instCred;
    int dataCred;
    int pushCount;
    int creditCount;
    int dataIssued;
    int dataDoneCount;
    int errCount;
    int testErrs;
    int passCount;
    int failCount;
    int cycles = 0;
    logic [31:0] expWord;
    int mark;

    memSubsys #(
        .QueueDepth (QueueDepth),
        .RamAddrW   (RamAddrW)
    ) memSubsys_inst (
        .clk          (clk),
        .rst          (rst),
        .i_ioFull     (ioFull),
        .i_instValid  (instValid),
        .i_instAddr   (instAddr),
        .o_instCredit (instCredit),
        .i_dataValid  (dataValid),
        .i_dataOp     (dataOp),
        .i_dataLen    (dataLen),
        .i_dataAddr   (dataAddr),
        .i_dataWdata  (dataWdata),
        .o_dataCredit (dataCredit),
        .o_instDone   (instDone),
        .o_instWord   (instWord),
        .o_dataDone   (dataDone),
        .o_dataRdata  (dataRdata)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TimeoutCycles) begin
            $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // requester credit model
    always @(negedge clk) begin
        if (rst) begin
            instCred = QueueDepth;
            dataCred = QueueDepth;
            pushCount = 0;
            creditCount = 0;
        end else begin
            instCred = instCred - int'(instValid) + int'(instCredit);
            dataCred = dataCred - int'(dataValid) + int'(dataCredit);
            pushCount += int'(instValid) + int'(dataValid);
            creditCount += int'(instCredit) + int'(dataCredit);
        end
    end

    creditRange: assert property (@(posedge clk) disable iff (rst)
        instCred >= 0 && instCred <= QueueDepth && dataCred >= 0 && dataCred <= QueueDepth)
        else begin
            $display("a requester credit counter left its range");
            errCount++;
        end

    always @(negedge clk) begin
        if (!rst && dataDone) begin
            dataDoneCount++;
            assert (dataExp.size() > 0) else begin
                $display("data done arrived with no data request outstanding");
                errCount++;
            end
            if (dataExp.size() > 0) begin
                expWord = dataExp.pop_front();
                assert (dataRdata == expWord) else begin
                    $display("FAILED o_dataRdata expected %h got %h", expWord, dataRdata);
                    errCount++;
                end
            end
        end
        if (!rst && instDone) begin
            assert (instExp.size() > 0) else begin
                $display("instruction done arrived with no fetch outstanding");
                errCount++;
            end
            if (instExp.size() > 0) begin
                expWord = instExp.pop_front();
                mark = fetchMark.pop_front();
                assert (instWord == expWord) else begin
                    $display("FAILED o_instWord expected %h got %h", expWord, instWord);
                    errCount++;
                end
                // data issued before this fetch must already be done
                assert (dataDoneCount >= mark) else begin
                    $display("a fetch finished ahead of an earlier data request");
                    errCount++;
                end
            end
        end
    end

    function automatic int randAddr();
        return $urandom_range(WindowBytes - 4);
    endfunction

    task automatic sendData(input memOpT op, input accessLenT len, input int addr,
                            input logic [31:0] wdata);
        int nBytes;
        int i;
        logic [31:0] word;
        nBytes = (len == len1) ? 1 : ((len == len2) ? 2 : 4);
        while (dataCred == 0) begin
            @(posedge clk);
            #1;
        end
        // little endian, zero above the access, zero for a store
        word = '0;
        for (i = 0; i < nBytes; i++) begin
            if (op == opStore) begin
                refMem[addr + i] = wdata[8*i +: 8];
            end else begin
                word[8*i +: 8] = refMem[addr + i];
            end
        end
        dataExp.push_back(word);
        dataIssued++;
        dataValid = 1'b1;
        dataOp = op;
        dataLen = len;
        dataAddr = memAddrW'(addr);
        dataWdata = wdata;
        @(posedge clk);
        #1;
        dataValid = 1'b0;
    endtask

    task automatic sendFetch(input int addr);
        int i;
        logic [31:0] word;
        while (instCred == 0) begin
            @(posedge clk);
            #1;
        end
        for (i = 0; i < 4; i++) begin
            word[8*i +: 8] = refMem[addr + i];
        end
        instExp.push_back(word);
        fetchMark.push_back(dataIssued);
        instValid = 1'b1;
        instAddr = memAddrW'(addr);
        @(posedge clk);
        #1;
        instValid = 1'b0;
    endtask

    task automatic waitIdle();
        while (dataExp.size() != 0 || instExp.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic endTest(input string name);
        if (errCount == testErrs) begin
            $display("test %s: ok", name);
            passCount++;
        end else begin
            $display("test %s: %0d errors", name, errCount - testErrs);
            failCount++;
        end
        testErrs = errCount;
    endtask

    initial begin
        int a;
        int k;
        int j;
        clk = 1'b0;
        rst = 1'b1;
        ioFull = 1'b0;
        instValid = 1'b0;
        instAddr = '0;
        dataValid = 1'b0;
        dataOp = opLoad;
        dataLen = len1;
        dataAddr = '0;
        dataWdata = '0;
        errCount = 0;
        testErrs = 0;
        passCount = 0;
        failCount = 0;
        dataIssued = 0;
        dataDoneCount = 0;
        void'($urandom(Seed));
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        for (a = 0; a < WindowBytes; a += 4) begin
            sendData(opStore, len4, a, $urandom());
        end
        waitIdle();
        endTest("fill");

        for (k = 0; k < 12; k++) begin
            a = randAddr();
            sendData(opStore, accessLenT'(k % 3), a, $urandom());
            sendData(opLoad, len1, a, '0);
            sendData(opLoad, len2, a, '0);
            sendData(opLoad, len4, a, '0);
        end
        waitIdle();
        endTest("round trip");

        for (k = 0; k < 12; k++) begin
            sendFetch(randAddr());
        end
        waitIdle();
        endTest("fetch");

        // both queues fill up behind a stall, data ahead of fetches, then drain
        ioFull = 1'b1;
        for (k = 0; k < QueueDepth; k++) begin
            sendData(opLoad, accessLenT'($urandom_range(2)), randAddr(), '0);
        end
        for (j = 0; j < QueueDepth; j++) begin
            sendFetch(randAddr());
        end
        ioFull = 1'b0;
        waitIdle();
        endTest("priority");

        a = randAddr();
        sendData(opStore, len4, a, $urandom());
        sendData(opLoad, len4, a, '0);
        sendFetch(a);
        repeat (5) @(posedge clk);
        #1;
        ioFull = 1'b1;
        repeat (6) @(posedge clk);
        #1;
        ioFull = 1'b0;
        waitIdle();
        endTest("stall");

        for (k = 0; k < 3; k++) begin
            sendData(opLoad, accessLenT'(k), randAddr(), '0);
            waitIdle();
            sendData(opStore, accessLenT'(k), randAddr(), $urandom());
            waitIdle();
        end
        sendFetch(randAddr());
        waitIdle();
        endTest("latency");

        assert (instCred == QueueDepth) else begin
            $display("FAILED instCred expected %h got %h", QueueDepth, instCred);
            errCount++;
        end
        assert (dataCred == QueueDepth) else begin
            $display("FAILED dataCred expected %h got %h", QueueDepth, dataCred);
            errCount++;
        end
        assert (creditCount == pushCount) else begin
            $display("FAILED creditCount expected %h got %h", pushCount, creditCount);
            errCount++;
        end
        endTest("credits");

        assert (memSubsys_inst.memSubsys_properties_inst.propErrs == 0) else begin
            $display("bound protocol or timing assertions failed %0d times",
                     memSubsys_inst.memSubsys_properties_inst.propErrs);
            errCount++;
        end
        endTest("protocol");

        $display("tests passed %0d failed %0d", passCount, failCount);
        if (errCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/memSubsys_properties.sv ====
module memSubsys_properties
    import memPkg::*;
#(
    parameter int QueueDepth = 4
) (
    input logic      clk,
    input logic      rst,
    input logic      i_ioFull,
    input logic      i_instValid,
    input logic      i_dataValid,
    input memOpT     i_dataOp,
    input accessLenT i_dataLen,
    input logic      i_instCredit,
    input logic      i_dataCredit,
    input logic      i_instDone,
    input logic      i_dataDone,
    input logic      i_memWe
);
    int instInFlight;
    int dataInFlight;
    int outstanding;
    int propErrs = 0;
    logic seenPush;
    // consecutive cycles without a stall, saturating
    logic [3:0] calm;

    always_ff @(posedge clk) begin
        if (rst) begin
            instInFlight <= 0;
            dataInFlight <= 0;
            outstanding  <= 0;
            seenPush     <= 1'b0;
            calm         <= '0;
        end else begin
            instInFlight <= instInFlight + int'(i_instValid) - int'(i_instCredit);
            dataInFlight <= dataInFlight + int'(i_dataValid) - int'(i_dataCredit);
            outstanding  <= outstanding + int'(i_instValid) + int'(i_dataValid)
                            - int'(i_instDone) - int'(i_dataDone);
            if (i_instValid || i_dataValid) begin
                seenPush <= 1'b1;
            end
            if (i_ioFull) begin
                calm <= '0;
            end else if (calm != 4'hf) begin
                calm <= calm + 4'd1;
            end
        end
    end

    instCreditHeld: assert property (@(posedge clk) disable iff (rst)
        i_instValid |-> instInFlight < QueueDepth)
        else begin
            propErrs++;
            $error("instruction valid sent without a credit");
        end

    dataCreditHeld: assert property (@(posedge clk) disable iff (rst)
        i_dataValid |-> dataInFlight < QueueDepth)
        else begin
            propErrs++;
            $error("data valid sent without a credit");
        end

    stallFreezes: assert property (@(posedge clk) disable iff (rst)
        i_ioFull |-> !i_instDone && !i_dataDone && !i_memWe)
        else begin
            propErrs++;
            $error("done or RAM write during an I/O stall");
        end

    quietAfterReset: assert property (@(posedge clk) disable iff (rst)
        !seenPush |-> !i_instDone && !i_dataDone && !i_instCredit && !i_dataCredit)
        else begin
            propErrs++;
            $error("done or credit pulse before the first request");
        end

    // a stall inside the window moves the done, so it excuses the check
    for (genvar k = 0; k < 3; k++) begin : gLatency
        localparam int N = (k == 2) ? 4 : k + 1;
        localparam logic [1:0] LenCode = k;

        loadLatency: assert property (@(posedge clk) disable iff (rst)
            outstanding == 0 && i_dataValid && i_dataOp == opLoad && i_dataLen == LenCode
            |-> ##(N + 2) (i_dataDone || i_ioFull || calm < N + 1))
            else begin
                propErrs++;
                $error("load of %0d bytes missed its latency", N);
            end

        storeLatency: assert property (@(posedge clk) disable iff (rst)
            outstanding == 0 && i_dataValid && i_dataOp == opStore && i_dataLen == LenCode
            |-> ##(N + 1) (i_dataDone || i_ioFull || calm < N))
            else begin
                propErrs++;
                $error("store of %0d bytes missed its latency", N);
            end
    end

    fetchLatency: assert property (@(posedge clk) disable iff (rst)
        outstanding == 0 && i_instValid && !i_dataValid
        |-> ##6 (i_instDone || i_ioFull || calm < 5))
        else begin
            propErrs++;
            $error("fetch missed its latency");
        end

endmodule

bind memSubsys memSubsys_properties #(
    .QueueDepth (QueueDepth)
) memSubsys_properties_inst (
    .clk          (clk),
    .rst          (rst),
    .i_ioFull     (i_ioFull),
    .i_instValid  (i_instValid),
    .i_dataValid  (i_dataValid),
    .i_dataOp     (i_dataOp),
    .i_dataLen    (i_dataLen),
    .i_instCredit (o_instCredit),
    .i_dataCredit (o_dataCredit),
    .i_instDone   (o_instDone),
    .i_dataDone   (o_dataDone),
    .i_memWe      (memWe)
);

// ==== hw/memSubsys.sv ====
module memSubsys
    import memPkg::*;
#(
    parameter int QueueDepth = 4,
    parameter int RamAddrW   = 10
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_ioFull,

    input  logic                i_instValid,
    input  logic [memAddrW-1:0] i_instAddr,
    output logic                o_instCredit,

    input  logic                i_dataValid,
    input  memOpT               i_dataOp,
    input  accessLenT           i_dataLen,
    input  logic [memAddrW-1:0] i_dataAddr,
    input  logic [31:0]         i_dataWdata,
    output logic                o_dataCredit,

    output logic                o_instDone,
    output logic [31:0]         o_instWord,
    output logic                o_dataDone,
    output logic [31:0]         o_dataRdata
);
    instReqT instPush;
    instReqT instHead;
    dataReqT dataPush;
    dataReqT dataHead;

    logic instNotEmpty;
    logic instPop;
    logic dataNotEmpty;
    logic dataPop;

    logic [memAddrW-1:0] memAddr;
    logic memWe;
    logic [7:0] memWdata;
    logic [7:0] memRdata;

    assign instPush.addr = i_instAddr;

    assign dataPush.addr  = i_dataAddr;
    assign dataPush.op    = i_dataOp;
    assign dataPush.len   = i_dataLen;
    assign dataPush.wdata = i_dataWdata;

    reqQueue #(
        .PayloadT   (instReqT),
        .QueueDepth (QueueDepth)
    ) instQueue_inst (
        .clk        (clk),
        .rst        (rst),
        .i_push     (i_instValid),
        .i_data     (instPush),
        .i_pop      (instPop),
        .o_notEmpty (instNotEmpty),
        .o_head     (instHead),
        .o_credit   (o_instCredit)
    );

    reqQueue #(
        .PayloadT   (dataReqT),
        .QueueDepth (QueueDepth)
    ) dataQueue_inst (
        .clk        (clk),
        .rst        (rst),
        .i_push     (i_dataValid),
        .i_data     (dataPush),
        .i_pop      (dataPop),
        .o_notEmpty (dataNotEmpty),
        .o_head     (dataHead),
        .o_credit   (o_dataCredit)
    );

    memCtrl memCtrl_inst (
        .clk           (clk),
        .rst           (rst),
        .i_ioFull      (i_ioFull),
        .i_instPending (instNotEmpty),
        .i_instReq     (instHead),
        .o_instPop     (instPop),
        .i_dataPending (dataNotEmpty),
        .i_dataReq     (dataHead),
        .o_dataPop     (dataPop),
        .o_memAddr     (memAddr),
        .o_memWe       (memWe),
        .o_memWdata    (memWdata),
        .i_memRdata    (memRdata),
        .o_instDone    (o_instDone),
        .o_instWord    (o_instWord),
        .o_dataDone    (o_dataDone),
        .o_dataRdata   (o_dataRdata)
    );

    byteRam #(
        .RamAddrW (RamAddrW)
    ) byteRam_inst (
        .clk     (clk),
        .i_addr  (memAddr),
        .i_we    (memWe),
        .i_wdata (memWdata),
        .o_rdata (memRdata)
    );

endmodule

// ==== hw/memCtrl/memCtrl.sv ====
module memCtrl
    import memPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                i_ioFull,

    input  logic                i_instPending,
    input  instReqT             i_instReq,
    output logic                o_instPop,

    input  logic                i_dataPending,
    input  dataReqT             i_dataReq,
    output logic                o_dataPop,

    output logic [memAddrW-1:0] o_memAddr,
    output logic                o_memWe,
    output logic [7:0]          o_memWdata,
    input  logic [7:0]          i_memRdata,

    output logic                o_instDone,
    output logic [31:0]         o_instWord,
    output logic                o_dataDone,
    output logic [31:0]         o_dataRdata
);
    typedef enum logic [1:0] {
        stIdle,
        stFetch,
        stLoad,
        stStore
    } ctrlStateT;

    ctrlStateT state;
    logic [2:0] stage;

    // latched request
    logic [memAddrW-1:0] reqAddr;
    logic [2:0] reqBytes;
    logic [31:0] reqWdata;

    // low three bytes of a read, the top byte comes straight from the RAM
    logic [23:0] asmReg;

    logic isRead;
    logic readDone;
    logic storeLast;
    logic [31:0] readWord;
    logic [memAddrW-1:0] byteOffset;

    function automatic logic [2:0] lenBytes(accessLenT len);
        case (len)
            len1: lenBytes = 3'd1;
            len2: lenBytes = 3'd2;
            default: lenBytes = 3'd4;
        endcase
    endfunction

    assign isRead = (state == stFetch) || (state == stLoad);
    assign readDone = isRead && (stage == reqBytes);
    assign storeLast = (state == stStore) && (stage == reqBytes - 3'd1);

    // data side wins when both queues are waiting
    assign o_dataPop = (state == stIdle) && !i_ioFull && i_dataPending;
    assign o_instPop = (state == stIdle) && !i_ioFull && !i_dataPending && i_instPending;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
            stage <= '0;
        end else if (!i_ioFull) begin
            case (state)
                stIdle: begin
                    stage <= '0;
                    if (i_dataPending) begin
                        state <= (i_dataReq.op == opStore) ? stStore : stLoad;
                    end else if (i_instPending) begin
                        state <= stFetch;
                    end
                end
                stFetch, stLoad: begin
                    if (readDone) begin
                        state <= stIdle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                stStore: begin
                    if (storeLast) begin
                        state <= stIdle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_dataPop) begin
            reqAddr  <= i_dataReq.addr;
            reqBytes <= lenBytes(i_dataReq.len);
            reqWdata <= i_dataReq.wdata;
        end else if (o_instPop) begin
            reqAddr  <= i_instReq.addr;
            reqBytes <= 3'd4;
        end
        // RAM output at stage k is byte k-1
        if (!i_ioFull && isRead && !readDone) begin
            case (stage)
                3'd1: asmReg[7:0] <= i_memRdata;
                3'd2: asmReg[15:8] <= i_memRdata;
                3'd3: asmReg[23:16] <= i_memRdata;
                default: asmReg <= asmReg;
            endcase
        end
    end

    // stalled reads re-address the previous byte so the RAM output
    // still holds byte stage-1 when the stall ends
    always_comb begin
        byteOffset = memAddrW'(stage);
        if (i_ioFull && isRead) begin
            byteOffset = byteOffset - 1'b1;
        end
    end

    assign o_memAddr = reqAddr + byteOffset;
    assign o_memWe = (state == stStore) && !i_ioFull;
    assign o_memWdata = reqWdata[{stage[1:0], 3'b000} +: 8];

    // zero-extended little-endian word
    always_comb begin
        case (reqBytes)
            3'd1: readWord = {24'd0, i_memRdata};
            3'd2: readWord = {16'd0, i_memRdata, asmReg[7:0]};
            default: readWord = {i_memRdata, asmReg};
        endcase
    end

    assign o_instDone = (state == stFetch) && readDone && !i_ioFull;
    assign o_instWord = readWord;

    assign o_dataDone = !i_ioFull && (((state == stLoad) && readDone) || storeLast);
    assign o_dataRdata = (state == stLoad) ? readWord : 32'd0;

endmodule

// ==== hw/memCtrl/byteRam.sv ====
module byteRam
    import memPkg::*;
#(
    parameter int RamAddrW = 10
) (
    input  logic                clk,
    input  logic [memAddrW-1:0] i_addr,
    input  logic                i_we,
    input  logic [7:0]          i_wdata,
    output logic [7:0]          o_rdata
);
    localparam int RamBytes = 2 ** RamAddrW;

    logic [7:0] mem [RamBytes];
    logic [RamAddrW-1:0] ramIdx;

    // upper address bits alias onto the same bytes
    assign ramIdx = i_addr[RamAddrW-1:0];

    // read returns the old byte on a same-address write
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[ramIdx] <= i_wdata;
        end
        o_rdata <= mem[ramIdx];
    end

endmodule

// ==== hw/reqQueue.sv ====
module reqQueue #(
    parameter type PayloadT  = logic [31:0],
    parameter int QueueDepth = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    i_push,
    input  PayloadT i_data,
    input  logic    i_pop,
    output logic    o_notEmpty,
    output PayloadT o_head,
    output logic    o_credit
);
    localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CountW = $clog2(QueueDepth + 1);
    localparam logic [PtrW-1:0] LastPtr = PtrW'(QueueDepth - 1);

    PayloadT storage [QueueDepth];

    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CountW-1:0] count;

    function automatic logic [PtrW-1:0] nextPtr(logic [PtrW-1:0] ptr);
        if (ptr == LastPtr) begin
            nextPtr = '0;
        end else begin
            nextPtr = ptr + 1'b1;
        end
    endfunction

    // requester never pushes without a credit, so no full check
    always_ff @(posedge clk) begin
        if (i_push) begin
            storage[wrPtr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (i_push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (i_pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({i_push, i_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per popped entry
            o_credit <= i_pop;
        end
    end

    assign o_notEmpty = (count != '0);
    assign o_head = storage[rdPtr];

endmodule

// ==== common/memPkg.sv ====
package memPkg;

    // byte address width of the whole system
    localparam int memAddrW = 16;

    typedef enum logic {
        opLoad  = 1'b0,
        opStore = 1'b1
    } memOpT;

    // bytes per data access
    typedef enum logic [1:0] {
        len1 = 2'd0,
        len2 = 2'd1,
        len4 = 2'd2
    } accessLenT;

    // fetches are always a full word
    typedef struct packed {
        logic [memAddrW-1:0] addr;
    } instReqT;

    typedef struct packed {
        logic [memAddrW-1:0] addr;
        memOpT               op;
        accessLenT           len;
        // only the low len bytes are written
        logic [31:0]         wdata;
    } dataReqT;

endpackage
